// File: tb.f
source/character_pkg.sv
source/button_sync.sv
source/wall_contact.sv
source/motion_fsm.sv
source/kinematics.sv
source/character_top.sv
verification/tb_character.sv

// File: Makefile
TOP := tb_character

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: verification/tb_character.sv
`timescale 1ns/1ps

module tb_character import character_pkg::*; ();

    // worst case ticks per test with four cycles per tick for the watchdog
    localparam int  tick_budget = 2 + 240 + 100 + 90 + 290;
    localparam real watchdog_ns = 40.0 * (4 * tick_budget + 300);

    logic   sys_clk;
    logic   sys_rst_n;
    logic   character_tick = 1'b0;
    btn_t   btn;
    phys_t  phys;
    state_t state;
    cnt_t   jump_cnt;
    face_t  face;

    logic [1:0] phase = '0;     // tick on every fourth cycle
    int errors;
    int tests_run;
    int tests_failed;
    int ticks_done;             // processed ticks as counted by the model
    int ticks_checked;

    // reference model
    state_t m_state;
    int     m_cnt;
    int     m_face;
    int     m_x;
    int     m_y;
    int     m_vx;
    int     m_vy;
    logic   m_latch;
    logic   m_tick_q;
    btn_t   m_btn_q;

    character_top character_top_i (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .character_tick (character_tick),
        .btn            (btn),
        .phys           (phys),
        .state          (state),
        .jump_cnt       (jump_cnt),
        .face           (face)
    );

    always #20 sys_clk = ~sys_clk;

    always @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phase          <= '0;
            character_tick <= 1'b0;
        end else begin
            phase          <= phase + 2'd1;
            character_tick <= (phase == 2'd3);
        end
    end

    function automatic int jump_factor(input int cnt);
        return 32 * (8 * ((cnt >> 6) & 7) + 4 * ((cnt >> 3) & 7) + (cnt & 7)) + 64;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    //--------------------------------------------------------------------
    // model steps once per processed tick
    //--------------------------------------------------------------------
    always @(posedge sys_clk or negedge sys_rst_n) begin
        bit     ground;
        bit     land;
        bit     hit;
        bit     latch_nxt;
        int     jf;
        int     vx;
        int     vy;
        int     dx;
        state_t nxt;
        if (!sys_rst_n) begin
            m_state  = st_idle;
            m_cnt    = 1;
            m_face   = 1;
            m_x      = 320;
            m_y      = 20;
            m_vx     = 0;
            m_vy     = 0;
            m_latch  = 1'b0;
            m_tick_q = 1'b0;
            m_btn_q  = '0;
        end else begin
            ground = (m_y == floor_y) && (m_vy == 0);
            land   = (m_y == floor_y) && (m_vy < 0);
            hit    = ((m_x == left_bound) && (m_vx > 0)) || ((m_x == right_bound) && (m_vx < 0));
            latch_nxt = m_latch;
            if (btn.jump && !m_btn_q.jump && ground) latch_nxt = 1'b1;
            else if (m_tick_q && m_state == st_jump) latch_nxt = 1'b0;
            if (m_tick_q) begin
                if (land || hit) nxt = st_collision;
                else if (m_state inside {st_idle, st_left, st_right}) begin
                    if (!ground) nxt = st_idle;
                    else if (m_btn_q.left) nxt = st_left;
                    else if (m_btn_q.right) nxt = st_right;
                    else if (m_latch) nxt = st_charge;
                    else nxt = st_idle;
                end else if (m_state == st_charge) begin
                    nxt = (m_cnt >= max_charge || !m_btn_q.jump) ? st_jump : st_charge;
                end else nxt = st_idle;
                jf = jump_factor(m_cnt);
                vx = m_vx;
                vy = m_vy;
                if (land) begin
                    vx = 0;
                    vy = 0;
                end else if (hit) begin
                    vx = -m_vx;         // reflect off the wall
                end else if (m_state == st_jump) begin
                    vx = m_vx + (jump_vel_x + (jf >>> 2)) * m_face;
                    vy = m_vy + jump_vel_y + jf;
                end
                // no gravity at rest or on the landing tick
                if (!land && !(ground && m_state != st_jump)) vy = vy + gravity;
                vx = clamp(vx, -max_vel, max_vel);
                vy = clamp(vy, -max_vel, max_vel);
                dx = (m_state == st_left) ? 1 : ((m_state == st_right) ? -1 : 0);
                m_x = clamp(m_x + dx + (vx >>> smooth_shift), right_bound, left_bound);
                m_y = m_y + (vy >>> smooth_shift);
                if (m_y < floor_y) m_y = floor_y;
                m_vx = vx;
                m_vy = vy;
                if (m_state == st_charge) m_cnt = m_cnt + charge_step;
                else if (m_state == st_jump) m_cnt = 1;
                if (hit) m_face = -m_face;
                else if (m_state == st_left) m_face = 1;
                else if (m_state == st_right) m_face = -1;
                m_state = nxt;
                ticks_done++;
            end
            m_latch  = latch_nxt;
            m_btn_q  = btn;
            m_tick_q = character_tick;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic compare_model();
        check_value("state", state, m_state);
        check_value("jump_cnt", jump_cnt, m_cnt);
        check_value("face", face, m_face);
        check_value("pos_x", phys.pos_x, m_x);
        check_value("pos_y", phys.pos_y, m_y);
        check_value("vel_x", phys.vel_x, m_vx);
        check_value("vel_y", phys.vel_y, m_vy);
    endtask

    // outputs are stable by the falling edge
    always @(negedge sys_clk) begin
        if (sys_rst_n && ticks_done != ticks_checked) begin
            ticks_checked = ticks_done;
            compare_model();
        end
    end

    task automatic wait_ticks(input int n);
        int target;
        target = ticks_done + n;
        wait (ticks_done >= target);
        @(negedge sys_clk);
    endtask

    task automatic apply_reset();
        @(posedge sys_clk);
        sys_rst_n <= 1'b0;
        btn       <= '0;
        repeat (3) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(negedge sys_clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    //--------------------------------------------------------------------
    // directed tests
    //--------------------------------------------------------------------
    task automatic reset_values();
        int e0;
        e0 = errors;
        apply_reset();
        check_value("state", state, st_idle);
        check_value("pos_x", phys.pos_x, 320);
        check_value("pos_y", phys.pos_y, 20);
        check_value("vel_x", phys.vel_x, 0);
        check_value("vel_y", phys.vel_y, 0);
        check_value("face", face, 1);
        check_value("jump_cnt", jump_cnt, 1);
        report_test("reset_values", e0);
    endtask

    task automatic walk_both_ways();
        int e0;
        e0 = errors;
        apply_reset();
        wait_ticks(1);
        @(posedge sys_clk);
        btn.right <= 1'b1;
        wait_ticks(200);
        check_value("pos_x", phys.pos_x, right_bound);
        check_value("face", face, -1);
        @(posedge sys_clk);
        btn.right <= 1'b0;
        btn.left  <= 1'b1;
        wait_ticks(30);
        // the first tick is still a step into the low x wall
        check_value("pos_x", phys.pos_x, right_bound + 29);
        check_value("face", face, 1);
        @(posedge sys_clk);
        btn.left <= 1'b0;
        wait_ticks(2);
        report_test("walk_both_ways", e0);
    endtask

    task automatic short_jump_and_landing();
        int e0;
        int cnt;
        int vx0;
        int vy0;
        int y0;
        int hits;
        int n;
        e0 = errors;
        apply_reset();
        wait_ticks(1);
        @(posedge sys_clk);
        btn.jump <= 1'b1;
        wait_ticks(1);
        check_value("state", state, st_charge);
        wait_ticks(5);
        @(posedge sys_clk);
        btn.jump <= 1'b0;
        wait_ticks(1);
        check_value("state", state, st_jump);
        check_value("jump_cnt", jump_cnt, 1 + 6 * charge_step);
        cnt = jump_cnt;
        vx0 = phys.vel_x;
        vy0 = phys.vel_y;
        wait_ticks(1);
        // launch facing higher x
        check_value("vel_x", phys.vel_x, vx0 + jump_vel_x + (jump_factor(cnt) >>> 2));
        check_value("vel_y", phys.vel_y, vy0 + jump_vel_y + jump_factor(cnt) + gravity);
        check_value("jump_cnt", jump_cnt, 1);
        hits = 0;
        n = 0;
        do begin
            y0 = phys.pos_y;
            vy0 = phys.vel_y;
            wait_ticks(1);
            n++;
            if (y0 > floor_y) check_value("vel_y", phys.vel_y, vy0 + gravity);
            if (state == st_collision) hits++;
        end while (!(hits > 0 && state == st_idle) && n < 80);
        check_value("pos_y", phys.pos_y, floor_y);
        check_value("collision ticks", hits, 1);
        check_value("vel_x", phys.vel_x, 0);
        check_value("vel_y", phys.vel_y, 0);
        check_value("state", state, st_idle);
        report_test("short_jump_and_landing", e0);
    endtask

    task automatic full_charge_jump();
        int e0;
        int n;
        e0 = errors;
        apply_reset();
        wait_ticks(1);
        @(posedge sys_clk);
        btn.jump <= 1'b1;
        n = 0;
        do begin
            wait_ticks(1);
            n++;
        end while (state != st_jump && n < 80);
        check_true(state == st_jump, "jump never started while the button was held");
        check_true(jump_cnt >= max_charge, "jump started before the charge was full");
        @(posedge sys_clk);
        btn.jump <= 1'b0;
        report_test("full_charge_jump", e0);
    endtask

    task automatic wall_bounce();
        int e0;
        int n;
        int x0;
        int vx0;
        e0 = errors;
        apply_reset();
        wait_ticks(1);
        @(posedge sys_clk);
        btn.left <= 1'b1;
        wait_ticks(121);    // walk toward the high x wall first
        @(posedge sys_clk);
        btn.left <= 1'b0;
        btn.jump <= 1'b1;
        n = 0;
        do begin
            wait_ticks(1);
            n++;
        end while (state != st_jump && n < 80);
        @(posedge sys_clk);
        btn.jump <= 1'b0;
        n = 0;
        do begin
            x0 = phys.pos_x;
            vx0 = phys.vel_x;
            wait_ticks(1);
            n++;
        end while (face != -2'sd1 && n < 80);
        check_true(face == -2'sd1, "character never turned around at the wall");
        check_value("pos_x", x0, left_bound);
        check_value("vel_x", phys.vel_x, -vx0);
        check_value("state", state, st_collision);
        report_test("wall_bounce", e0);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: tests did not finish within the tick budget");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        btn       = '0;
        reset_values();
        walk_both_ways();
        short_jump_and_landing();
        full_charge_jump();
        wall_bounce();
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: source/character_top.sv
`timescale 1ns/1ps

module character_top import character_pkg::*; (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   character_tick,
    input  btn_t   btn,
    output phys_t  phys,
    output state_t state,
    output cnt_t   jump_cnt,
    output face_t  face
);

    btn_t     btn_q;
    logic     jump_rise;
    logic     tick_q;
    contact_t contact;

    //----------------------------------------------------------------------
    // input stage
    //----------------------------------------------------------------------
    button_sync button_sync_i (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .character_tick (character_tick),
        .btn            (btn),
        .btn_q          (btn_q),
        .jump_rise      (jump_rise),
        .tick_q         (tick_q)
    );

    // combinational, from the stored physics
    wall_contact wall_contact_i (
        .phys    (phys),
        .contact (contact)
    );

    //----------------------------------------------------------------------
    // control and physics, both step on tick_q
    //----------------------------------------------------------------------
    motion_fsm motion_fsm_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick_q    (tick_q),
        .btn_q     (btn_q),
        .jump_rise (jump_rise),
        .contact   (contact),
        .state     (state),
        .jump_cnt  (jump_cnt),
        .face      (face)
    );

    kinematics kinematics_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick_q    (tick_q),
        .state     (state),
        .jump_cnt  (jump_cnt),
        .face      (face),
        .contact   (contact),
        .phys      (phys)
    );

endmodule

// File: source/kinematics.sv
`timescale 1ns/1ps

module kinematics import character_pkg::*; (
    input  logic     sys_clk,
    input  logic     sys_rst_n,
    input  logic     tick_q,
    input  state_t   state,
    input  cnt_t     jump_cnt,
    input  face_t    face,
    input  contact_t contact,
    output phys_t    phys
);

    phy_t  jf;
    phy_t  dvel_x;
    phy_t  dvel_y;
    phy_t  acc_y;
    phy_t  vel_x_nxt;
    phy_t  vel_y_nxt;
    phy_t  disp_x;
    phy_t  pos_x_sum;
    phy_t  pos_y_sum;
    phys_t phys_nxt;
    logic  jumping;

    function automatic phy_t clamp_vel(input phy_t v);
        if (v > max_vel) begin
            return max_vel;
        end else if (v < -max_vel) begin
            return -max_vel;
        end
        return v;
    endfunction

    //----------------------------------------------------------------------
    // jump factor from the charge count
    //----------------------------------------------------------------------
    // three 3-bit groups weighted 256, 128 and 32, plus a fixed 64
    assign jf = phy_t'({jump_cnt[8:6], 8'b0}) + phy_t'({jump_cnt[5:3], 7'b0})
              + phy_t'({jump_cnt[2:0], 5'b0}) + phy_t'(64);

    assign jumping = (state == st_jump);

    //----------------------------------------------------------------------
    // velocity step
    //----------------------------------------------------------------------
    always_comb begin
        if (contact.landing) begin
            dvel_x = -phys.vel_x;               // stop dead
            dvel_y = -phys.vel_y;
        end else if (contact.side_hit) begin
            dvel_x = -(phys.vel_x <<< 1);       // net result is -vel_x
            dvel_y = '0;
        end else if (jumping) begin
            dvel_x = (jump_vel_x + (jf >>> 2)) * face;
            dvel_y = jump_vel_y + jf;
        end else begin
            dvel_x = '0;
            dvel_y = '0;
        end
    end

    // no gravity while resting, nor on the landing tick itself
    assign acc_y = ((contact.on_ground && !jumping) || contact.landing) ? '0 : gravity;

    assign vel_x_nxt = clamp_vel(phys.vel_x + dvel_x);
    assign vel_y_nxt = clamp_vel(phys.vel_y + dvel_y + acc_y);

    //----------------------------------------------------------------------
    // position step
    //----------------------------------------------------------------------
    always_comb begin
        case (state)
            st_left:  disp_x = phy_t'(1);
            st_right: disp_x = -phy_t'(1);
            default:  disp_x = '0;
        endcase
    end

    assign pos_x_sum = phys.pos_x + disp_x + (vel_x_nxt >>> smooth_shift);
    assign pos_y_sum = phys.pos_y + (vel_y_nxt >>> smooth_shift);

    always_comb begin
        phys_nxt.vel_x = vel_x_nxt;
        phys_nxt.vel_y = vel_y_nxt;
        if (pos_x_sum < right_bound) begin
            phys_nxt.pos_x = right_bound;
        end else if (pos_x_sum > left_bound) begin
            phys_nxt.pos_x = left_bound;
        end else begin
            phys_nxt.pos_x = pos_x_sum;
        end
        phys_nxt.pos_y = (pos_y_sum < floor_y) ? floor_y : pos_y_sum;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phys.pos_x <= init_pos_x;
            phys.pos_y <= init_pos_y;
            phys.vel_x <= '0;
            phys.vel_y <= '0;
        end else if (tick_q) begin
            phys <= phys_nxt;
        end
    end

endmodule

// File: source/motion_fsm.sv
`timescale 1ns/1ps

module motion_fsm import character_pkg::*; (
    input  logic     sys_clk,
    input  logic     sys_rst_n,
    input  logic     tick_q,
    input  btn_t     btn_q,
    input  logic     jump_rise,
    input  contact_t contact,
    output state_t   state,
    output cnt_t     jump_cnt,
    output face_t    face
);

    state_t state_nxt;
    logic   jump_latch;
    logic   charge_done;

    //----------------------------------------------------------------------
    // jump request latch
    //----------------------------------------------------------------------
    // set on any cycle, cleared only by a processed tick in the jump state
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_latch <= 1'b0;
        end else if (jump_rise && contact.on_ground) begin
            jump_latch <= 1'b1;
        end else if (tick_q && (state == st_jump)) begin
            jump_latch <= 1'b0;
        end
    end

    // full charge or button let go
    assign charge_done = (jump_cnt >= max_charge) || !btn_q.jump;

    //----------------------------------------------------------------------
    // next state
    //----------------------------------------------------------------------
    always_comb begin
        if (contact.landing || contact.side_hit) begin
            state_nxt = st_collision;
        end else begin
            case (state)
                st_idle, st_left, st_right: begin
                    if (!contact.on_ground) begin
                        state_nxt = st_idle;
                    end else if (btn_q.left) begin
                        state_nxt = st_left;
                    end else if (btn_q.right) begin
                        state_nxt = st_right;
                    end else if (jump_latch) begin
                        state_nxt = st_charge;
                    end else begin
                        state_nxt = st_idle;
                    end
                end
                st_charge: begin
                    state_nxt = charge_done ? st_jump : st_charge;
                end
                st_jump, st_collision: begin
                    state_nxt = st_idle;   // launch and bounce last one tick
                end
                default: begin
                    state_nxt = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= st_idle;
        end else if (tick_q) begin
            state <= state_nxt;
        end
    end

    //----------------------------------------------------------------------
    // charge counter
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_cnt <= cnt_t'(1);
        end else if (tick_q) begin
            if (state == st_charge) begin
                jump_cnt <= jump_cnt + charge_step;
            end else if (state == st_jump) begin
                jump_cnt <= cnt_t'(1);   // back to base after launch
            end
        end
    end

    //----------------------------------------------------------------------
    // facing
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= 2'sd1;
        end else if (tick_q) begin
            if (contact.side_hit) begin
                face <= -face;          // turn around off the wall
            end else if (state == st_left) begin
                face <= 2'sd1;
            end else if (state == st_right) begin
                face <= -2'sd1;
            end
        end
    end

endmodule

// File: source/wall_contact.sv
`timescale 1ns/1ps

module wall_contact import character_pkg::*; (
    input  phys_t    phys,
    output contact_t contact
);

    logic at_floor;
    logic at_left;
    logic at_right;
    logic vel_y_zero;
    logic falling;
    logic moving_up_x;
    logic moving_down_x;

    //----------------------------------------------------------------------
    // boundary touch
    //----------------------------------------------------------------------
    assign at_floor = (phys.pos_y == floor_y);
    assign at_left  = (phys.pos_x == left_bound);   // high x side
    assign at_right = (phys.pos_x == right_bound);  // low x side

    // velocity signs
    assign vel_y_zero    = (phys.vel_y == '0);
    assign falling       = (phys.vel_y < 0);
    assign moving_up_x   = (phys.vel_x > 0);
    assign moving_down_x = (phys.vel_x < 0);

    //----------------------------------------------------------------------
    // contact conditions
    //----------------------------------------------------------------------
    // positions are clamped before they are stored, so a wall only counts
    // when the character presses into it
    always_comb begin
        contact.on_ground = at_floor && vel_y_zero;
        contact.landing   = at_floor && falling;
        contact.side_hit  = (at_left && moving_up_x) || (at_right && moving_down_x);
    end

endmodule

// File: source/button_sync.sv
`timescale 1ns/1ps

module button_sync import character_pkg::*; (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic character_tick,
    input  btn_t btn,
    output btn_t btn_q,
    output logic jump_rise,
    output logic tick_q
);

    //----------------------------------------------------------------------
    // input registers
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            btn_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            btn_q  <= btn;             // levels, one stage
            tick_q <= character_tick;  // world update strobe
        end
    end

    // jump pressed this cycle but not last cycle
    assign jump_rise = btn.jump & ~btn_q.jump;

endmodule

// File: source/character_pkg.sv
package character_pkg;

    //----------------------------------------------------------------------
    // physics word format
    //----------------------------------------------------------------------
    localparam int phy_w        = 17;
    localparam int smooth_shift = 8;    // fraction bits of a velocity
    localparam int cnt_w        = 16;

    typedef logic signed [phy_w-1:0] phy_t;
    typedef logic [cnt_w-1:0]        cnt_t;

    // +1 faces toward higher x, -1 toward lower x
    typedef logic signed [1:0] face_t;

    //----------------------------------------------------------------------
    // world geometry
    //----------------------------------------------------------------------
    localparam int wall_w    = 40;
    localparam int map_x_off = 140;
    localparam int map_w     = 480;
    localparam int char_w_x  = 42;

    // right wall sits at low x, left wall at high x
    localparam phy_t right_bound = phy_t'(map_x_off + wall_w);          // lowest legal x
    localparam phy_t left_bound  = phy_t'(map_w - wall_w + map_x_off - char_w_x);
    localparam phy_t floor_y     = phy_t'(20);

    localparam phy_t init_pos_x = phy_t'(320);
    localparam phy_t init_pos_y = phy_t'(20);

    //----------------------------------------------------------------------
    // physics constants, velocities in 1/256 pixel per tick
    //----------------------------------------------------------------------
    localparam phy_t gravity    = phy_t'(-256);
    localparam phy_t max_vel    = phy_t'(14848);   // clamp magnitude
    localparam phy_t jump_vel_x = phy_t'(512);
    localparam phy_t jump_vel_y = phy_t'(1536);

    localparam cnt_t max_charge  = cnt_t'(500);
    localparam cnt_t charge_step = cnt_t'(10);

    //----------------------------------------------------------------------
    // movement states
    //----------------------------------------------------------------------
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_left      = 3'd1,   // walking toward higher x
        st_right     = 3'd2,   // walking toward lower x
        st_charge    = 3'd3,
        st_jump      = 3'd4,
        st_collision = 3'd5
    } state_t;

    //----------------------------------------------------------------------
    // bundles
    //----------------------------------------------------------------------
    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } btn_t;

    typedef struct packed {
        phy_t pos_x;
        phy_t pos_y;
        phy_t vel_x;
        phy_t vel_y;
    } phys_t;

    typedef struct packed {
        logic on_ground;   // resting on the floor
        logic landing;     // touching the floor while still falling
        logic side_hit;    // touching a side wall while moving into it
    } contact_t;

endpackage
